//--- rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);

  logic [rv_pkg::SHAMT_W-1:0] shamt;

  // shift amount from the low bits of b
  assign shamt = b[rv_pkg::SHAMT_W-1:0];

  always_comb
  begin
    case (op)
      rv_pkg::ALU_ADD:
      begin
        result = a + b;
      end
      rv_pkg::ALU_SUB:
      begin
        result = a - b;
      end
      rv_pkg::ALU_SLL:
      begin
        result = a << shamt;
      end
      rv_pkg::ALU_SLT:
      begin
        // two's complement compare
        result = rv_pkg::word_t'($signed(a) < $signed(b));
      end
      rv_pkg::ALU_SLTU:
      begin
        result = rv_pkg::word_t'(a < b);
      end
      rv_pkg::ALU_XOR:
      begin
        result = a ^ b;
      end
      rv_pkg::ALU_SRL:
      begin
        result = a >> shamt;
      end
      rv_pkg::ALU_SRA:
      begin
        // fills with the sign bit
        result = $signed(a) >>> shamt;
      end
      rv_pkg::ALU_OR:
      begin
        result = a | b;
      end
      rv_pkg::ALU_AND:
      begin
        result = a & b;
      end
      default:
      begin
        result = '0;
      end
    endcase
  end

endmodule

//--- rv_core.f
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_decoder.sv
rv_alu.sv
rv_pc_unit.sv
rv_core.sv
rv_core_tb.sv

//--- rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic           clk,
  input  logic           rst,
  input  rv_pkg::word_t  insn,
  output rv_pkg::word_t  pc,
  output rv_pkg::store_t store,
  output logic           halt,
  output logic           illegal
);

  rv_pkg::dec_t dec;
  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t alu_a;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t wb_data;
  logic commit;

  rv_decoder u_decoder (
    .insn (insn),
    .dec  (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (dec.rf_we && commit),
    .rd       (dec.rd),
    .rd_data  (wb_data)
  );

  // operand select, PC for AUIPC and immediate for I/S/U forms
  assign alu_a = dec.use_pc ? pc : rs1_data;
  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  rv_alu u_alu (
    .op     (dec.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_pc_unit u_pc_unit (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .pc         (pc),
    .pc_plus4   (pc_plus4)
  );

  // links write the return address
  assign wb_data = dec.wb_link ? pc_plus4 : alu_result;

  // nothing commits while stopped on ECALL or a bad encoding
  assign commit = !(dec.is_halt || dec.illegal);

  always_comb
  begin
    store.addr = alu_result;
    store.data = rs2_data;
    store.we = (dec.is_store && commit) ? rv_pkg::STORE_WE_WORD : '0;
  end

  assign halt = dec.is_halt;
  assign illegal = dec.illegal;

endmodule

//--- rv_core_tb_prog.svh
`ifndef RV_CORE_TB_PROG_SVH
`define RV_CORE_TB_PROG_SVH

// one encoder per instruction format
function automatic rv_pkg::word_t enc_r(logic [6:0] f7, rv_pkg::reg_idx_t rs2,
                                        rv_pkg::reg_idx_t rs1, logic [2:0] f3,
                                        rv_pkg::reg_idx_t rd);
  return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG_REG};
endfunction

function automatic rv_pkg::word_t enc_i(logic [11:0] imm, rv_pkg::reg_idx_t rs1, logic [2:0] f3,
                                        rv_pkg::reg_idx_t rd, rv_pkg::opcode_e op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic rv_pkg::word_t enc_s(logic [11:0] imm, rv_pkg::reg_idx_t rs2,
                                        rv_pkg::reg_idx_t rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
endfunction

function automatic rv_pkg::word_t enc_b(logic [12:0] imm, rv_pkg::reg_idx_t rs2,
                                        rv_pkg::reg_idx_t rs1, logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
endfunction

function automatic rv_pkg::word_t enc_u(logic [19:0] imm, rv_pkg::reg_idx_t rd,
                                        rv_pkg::opcode_e op);
  return {imm, rd, op};
endfunction

function automatic rv_pkg::word_t enc_j(logic [20:0] imm, rv_pkg::reg_idx_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
endfunction

task automatic emit_insn(rv_pkg::word_t w);
  imem[prog_len] = w;
  prog_len++;
endtask

// LUI/ADDI pair with the upper part rounded for the sign of the low 12 bits
task automatic load_reg(rv_pkg::reg_idx_t rd, rv_pkg::word_t value);
  rv_pkg::word_t upper;
  upper = value + 32'h800;
  emit_insn(enc_u(upper[31:12], rd, rv_pkg::OP_LUI));
  emit_insn(enc_i(value[11:0], rd, 3'b000, rd, rv_pkg::OP_REG_IMM));
endtask

// SW of rs2 into the next free result slot
task automatic expect_store(string name, rv_pkg::reg_idx_t rs2, rv_pkg::word_t value);
  logic [11:0] offset;
  offset = 12'(DATA_BASE + 4 * exp_count);
  emit_insn(enc_s(offset, rs2, 0));
  exp_addr[exp_count] = rv_pkg::word_t'(offset);
  exp_data[exp_count] = value;
  exp_name[exp_count] = name;
  exp_count++;
endtask

// store of the poison word in x4 that must never execute
task automatic emit_poison();
  emit_insn(enc_s(12'h7fc, 4, 0));
endtask

task automatic test_reg_reg(string name, logic [6:0] f7, logic [2:0] f3,
                            rv_pkg::reg_idx_t rs1, rv_pkg::reg_idx_t rs2,
                            rv_pkg::word_t value);
  emit_insn(enc_r(f7, rs2, rs1, f3, 3));
  expect_store(name, 3, value);
endtask

task automatic test_reg_imm(string name, logic [2:0] f3, logic [11:0] imm,
                            rv_pkg::reg_idx_t rs1, rv_pkg::word_t value);
  emit_insn(enc_i(imm, rs1, f3, 3, rv_pkg::OP_REG_IMM));
  expect_store(name, 3, value);
endtask

task automatic test_branch(string name, rv_pkg::br_op_e op, rv_pkg::reg_idx_t rs1,
                           rv_pkg::reg_idx_t rs2, logic taken);
  emit_insn(enc_b(13'd8, rs2, rs1, op));
  if (taken)
    emit_poison();
  else
    expect_store({name, " fall"}, 6, FALL_MARK);
  expect_store({name, " target"}, 5, TARGET_MARK);
endtask

task automatic build_program();
  rv_pkg::word_t a;
  rv_pkg::word_t b;
  rv_pkg::word_t immx;
  rv_pkg::word_t u;
  rv_pkg::word_t here;
  logic [11:0] imm;
  logic [4:0] sh;
  // a negative and b positive so that signed and unsigned orders disagree
  a = $random(seed) | 32'h8000_0000;
  // b is odd so the shift amount in b[4:0] is never zero
  b = ($random(seed) & 32'h7fff_ffff) | 32'h0000_0001;
  imm = 12'($random(seed));
  immx = {{20{imm[11]}}, imm};
  sh = b[4:0];
  load_reg(1, a);
  load_reg(2, b);
  load_reg(4, POISON);
  load_reg(5, TARGET_MARK);
  load_reg(6, FALL_MARK);
  test_reg_reg("add", 7'h00, 3'h0, 1, 2, a + b);
  test_reg_reg("sub", 7'h20, 3'h0, 1, 2, a - b);
  test_reg_reg("xor", 7'h00, 3'h4, 1, 2, a ^ b);
  test_reg_reg("or", 7'h00, 3'h6, 1, 2, a | b);
  test_reg_reg("and", 7'h00, 3'h7, 1, 2, a & b);
  test_reg_reg("sll", 7'h00, 3'h1, 1, 2, a << sh);
  test_reg_reg("srl", 7'h00, 3'h5, 1, 2, a >> sh);
  test_reg_reg("sra", 7'h20, 3'h5, 1, 2, $signed(a) >>> sh);
  test_reg_reg("slt", 7'h00, 3'h2, 1, 2, {31'b0, $signed(a) < $signed(b)});
  test_reg_reg("slt rev", 7'h00, 3'h2, 2, 1, {31'b0, $signed(b) < $signed(a)});
  test_reg_reg("sltu", 7'h00, 3'h3, 1, 2, {31'b0, a < b});
  test_reg_reg("sltu rev", 7'h00, 3'h3, 2, 1, {31'b0, b < a});
  test_reg_imm("addi", 3'h0, imm, 1, a + immx);
  test_reg_imm("xori", 3'h4, imm, 1, a ^ immx);
  test_reg_imm("ori", 3'h6, imm, 1, a | immx);
  test_reg_imm("andi", 3'h7, imm, 1, a & immx);
  test_reg_imm("slti", 3'h2, imm, 1, {31'b0, $signed(a) < $signed(immx)});
  test_reg_imm("slti pos", 3'h2, imm, 2, {31'b0, $signed(b) < $signed(immx)});
  test_reg_imm("sltiu", 3'h3, imm, 1, {31'b0, a < immx});
  test_reg_imm("sltiu pos", 3'h3, imm, 2, {31'b0, b < immx});
  test_reg_imm("slli", 3'h1, {7'h00, sh}, 1, a << sh);
  test_reg_imm("srli", 3'h5, {7'h00, sh}, 1, a >> sh);
  test_reg_imm("srai", 3'h5, {7'h20, sh}, 1, $signed(a) >>> sh);
  u = $random(seed);
  emit_insn(enc_u(u[19:0], 3, rv_pkg::OP_LUI));
  expect_store("lui", 3, {u[19:0], 12'b0});
  here = rv_pkg::word_t'(prog_len * 4);
  emit_insn(enc_u(u[31:12], 3, rv_pkg::OP_AUIPC));
  expect_store("auipc", 3, here + {u[31:12], 12'b0});
  // each condition once taken and once not taken
  // signed a < 0 <= b while unsigned b < a
  test_branch("beq t", rv_pkg::BR_EQ, 1, 1, 1'b1);
  test_branch("beq n", rv_pkg::BR_EQ, 1, 2, 1'b0);
  test_branch("bne t", rv_pkg::BR_NE, 1, 2, 1'b1);
  test_branch("bne n", rv_pkg::BR_NE, 2, 2, 1'b0);
  test_branch("blt t", rv_pkg::BR_LT, 1, 2, 1'b1);
  test_branch("blt n", rv_pkg::BR_LT, 2, 1, 1'b0);
  test_branch("bge t", rv_pkg::BR_GE, 2, 1, 1'b1);
  test_branch("bge n", rv_pkg::BR_GE, 1, 2, 1'b0);
  test_branch("bltu t", rv_pkg::BR_LTU, 2, 1, 1'b1);
  test_branch("bltu n", rv_pkg::BR_LTU, 1, 2, 1'b0);
  test_branch("bgeu t", rv_pkg::BR_GEU, 1, 2, 1'b1);
  test_branch("bgeu n", rv_pkg::BR_GEU, 2, 1, 1'b0);
  here = rv_pkg::word_t'(prog_len * 4);
  emit_insn(enc_j(21'd8, 7));
  emit_poison();
  expect_store("jal link", 7, here + 4);
  // x8 holds target - 4 plus one so the JALR must drop bit 0
  here = rv_pkg::word_t'((prog_len + 2) * 4);
  load_reg(8, here + 5);
  emit_insn(enc_i(12'd4, 8, 3'b000, 9, rv_pkg::OP_JALR));
  emit_poison();
  expect_store("jalr link", 9, here + 4);
  halt_addr = rv_pkg::word_t'(prog_len * 4);
  emit_insn(32'h0000_0073);
endtask

`endif

//--- rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

  localparam rv_pkg::word_t POISON = 32'hdead_beef;
  localparam rv_pkg::word_t TARGET_MARK = 32'h7a59_e7c1;
  localparam rv_pkg::word_t FALL_MARK = 32'h0fa1_1000;
  localparam int DATA_BASE = 'h100;
  localparam int MAX_STORES = 64;
  localparam int HOLD_CYCLES = 5;
  localparam int BAD_SLOT = 2;

  logic clk;
  logic rst;
  rv_pkg::word_t insn;
  rv_pkg::word_t pc;
  rv_pkg::store_t store;
  logic halt;
  logic illegal;

  rv_pkg::word_t imem [256];
  rv_pkg::word_t dmem [512];
  rv_pkg::word_t exp_addr [MAX_STORES];
  rv_pkg::word_t exp_data [MAX_STORES];
  string exp_name [MAX_STORES];
  int exp_count = 0;
  int prog_len = 0;
  int store_idx = 0;
  int value_errors = 0;
  int other_errors = 0;
  logic prog_ready = 1'b0;
  integer seed;
  rv_pkg::word_t halt_addr;

  `include "rv_core_tb_prog.svh"

  rv_core UUT (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .store   (store),
    .halt    (halt),
    .illegal (illegal)
  );

  always
  begin
    clk = 1'b0;
    #5;
    clk = 1'b1;
    #5;
  end

  // instruction memory answers in the same cycle
  assign insn = imem[pc[9:2]];

  // data memory write and store count at each commit
  always @(posedge clk)
  begin
    if (!rst && store.we != '0)
    begin
      dmem[store.addr[10:2]] <= store.data;
      store_idx <= store_idx + 1;
    end
  end

  // outputs are sampled at the falling edge away from any change
  reset_state_ok: assert property (@(negedge clk)
    $past(rst) |-> (pc == rv_pkg::RESET_PC && store.we == '0 && !halt && !illegal))
  else
  begin
    $display("reset state wrong: pc %h we %h halt %b illegal %b", pc, store.we, halt, illegal);
    other_errors++;
  end

  store_addr_ok: assert property (@(negedge clk) disable iff (rst)
    (store.we != '0 && store_idx < exp_count) |-> store.addr == exp_addr[store_idx])
  else
  begin
    $display("ERROR %s address expected %h actual %h",
             exp_name[store_idx], exp_addr[store_idx], store.addr);
    value_errors++;
  end

  store_data_ok: assert property (@(negedge clk) disable iff (rst)
    (store.we != '0 && store_idx < exp_count) |-> store.data == exp_data[store_idx])
  else
  begin
    $display("ERROR %s data expected %h actual %h",
             exp_name[store_idx], exp_data[store_idx], store.data);
    value_errors++;
  end

  store_word_ok: assert property (@(negedge clk) disable iff (rst)
    (store.we != '0) |-> store.we == rv_pkg::STORE_WE_WORD)
  else
  begin
    $display("ERROR sw byte enables expected %h actual %h", rv_pkg::STORE_WE_WORD, store.we);
    value_errors++;
  end

  no_poison: assert property (@(negedge clk) disable iff (rst)
    (store.we != '0) |-> store.data != POISON)
  else
  begin
    $display("a skipped instruction executed and stored poison at %h", store.addr);
    other_errors++;
  end

  no_extra_store: assert property (@(negedge clk) disable iff (rst)
    (store.we != '0) |-> store_idx < exp_count)
  else
  begin
    $display("unexpected store to %h after the last expected one", store.addr);
    other_errors++;
  end

  // pc holds and nothing is stored while stopped
  stop_holds: assert property (@(negedge clk) disable iff (rst)
    ($past(halt || illegal) && (halt || illegal)) |-> (pc == $past(pc) && store.we == '0))
  else
  begin
    $display("core moved while stopped: pc %h we %h", pc, store.we);
    other_errors++;
  end

  initial
  begin
    rst = 1'b1;
    seed = 32'hd007c5fb;
    // unused slots hold an undefined opcode tagged with their index
    for (int i = 0; i < 256; i++)
      imem[i] = {25'(i), 7'h7f};
    for (int i = 0; i < 512; i++)
      dmem[i] = ~rv_pkg::word_t'(i * 4);
    build_program();
    prog_ready = 1'b1;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    do
      @(negedge clk);
    while (!(halt || illegal));
    assert (halt && !illegal)
    else
    begin
      $display("core stopped on an illegal instruction instead of ecall");
      other_errors++;
    end
    repeat (HOLD_CYCLES) @(negedge clk);
    assert (halt && pc == halt_addr)
    else
    begin
      $display("ERROR ecall pc expected %h actual %h", halt_addr, pc);
      value_errors++;
    end
    assert (store_idx == exp_count)
    else
    begin
      $display("only %0d of %0d expected stores were seen", store_idx, exp_count);
      other_errors++;
    end
    // every result slot in data memory holds its stored word
    for (int k = 0; k < exp_count; k++)
    begin
      assert (dmem[exp_addr[k][10:2]] == exp_data[k])
      else
      begin
        $display("ERROR %s memory expected %h actual %h", exp_name[k], exp_data[k],
                 dmem[exp_addr[k][10:2]]);
        value_errors++;
      end
    end
    // second run stops on an undefined opcode
    @(posedge clk);
    #1 rst = 1'b1;
    imem[BAD_SLOT] = 32'h0000_007f;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    do
      @(negedge clk);
    while (!(halt || illegal));
    repeat (HOLD_CYCLES) @(negedge clk);
    assert (illegal && !halt && pc == rv_pkg::word_t'(BAD_SLOT * 4))
    else
    begin
      $display("ERROR illegal pc expected %h actual %h", BAD_SLOT * 4, pc);
      value_errors++;
    end
    $display("errors: %0d value, %0d other, %0d of %0d stores",
             value_errors, other_errors, store_idx, exp_count);
    if (value_errors + other_errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // bound covers both runs
  initial
  begin
    wait (prog_ready);
    repeat (2 * (10 + prog_len + 20)) @(posedge clk);
    $display("timeout: the core never halted within %0d cycles", 2 * (10 + prog_len + 20));
    $display("sim failed");
    $finish;
  end

endmodule

//--- rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder (
  input  rv_pkg::word_t insn,
  output rv_pkg::dec_t  dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic base_f7;
  logic alt_f7;
  logic imm_f7_ok;
  logic reg_f7_ok;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_j;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // immediates, sign taken from insn[31]
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  assign base_f7 = (funct7 == rv_pkg::FUNCT7_BASE);
  assign alt_f7 = (funct7 == rv_pkg::FUNCT7_ALT);

  // in the reg-imm group only the shifts carry a funct7
  assign imm_f7_ok = (funct3 == rv_pkg::FUNCT3_SLL) ? base_f7 :
                     (funct3 == rv_pkg::FUNCT3_SRX) ? (base_f7 || alt_f7) : 1'b1;

  // alternate funct7 only for SUB and SRA
  assign reg_f7_ok = base_f7 ||
                     (alt_f7 && ((funct3 == rv_pkg::FUNCT3_ADD) ||
                                 (funct3 == rv_pkg::FUNCT3_SRX)));

  always_comb
  begin
    dec = '0;
    dec.rs1 = insn[19:15];
    dec.rs2 = insn[24:20];
    dec.rd = insn[11:7];
    dec.imm = imm_i;
    dec.alu_op = rv_pkg::ALU_ADD;
    dec.br_op = rv_pkg::BR_EQ;
    case (rv_pkg::opcode_e'(opcode))
      rv_pkg::OP_LUI:
      begin
        // x0 plus the upper immediate
        dec.rs1 = '0;
        dec.imm = imm_u;
        dec.use_imm = 1'b1;
        dec.rf_we = 1'b1;
      end
      rv_pkg::OP_AUIPC:
      begin
        dec.imm = imm_u;
        dec.use_pc = 1'b1;
        dec.use_imm = 1'b1;
        dec.rf_we = 1'b1;
      end
      rv_pkg::OP_JAL:
      begin
        dec.imm = imm_j;
        dec.is_jal = 1'b1;
        dec.rf_we = 1'b1;
        dec.wb_link = 1'b1;
      end
      rv_pkg::OP_JALR:
      begin
        if (funct3 == rv_pkg::FUNCT3_ADD)
        begin
          // target computed by the ALU as rs1 + imm
          dec.use_imm = 1'b1;
          dec.is_jalr = 1'b1;
          dec.rf_we = 1'b1;
          dec.wb_link = 1'b1;
        end
        else
        begin
          dec.illegal = 1'b1;
        end
      end
      rv_pkg::OP_BRANCH:
      begin
        // funct3 010 and 011 are unused
        if (funct3[2:1] != 2'b01)
        begin
          dec.imm = imm_b;
          dec.is_branch = 1'b1;
          dec.br_op = rv_pkg::br_op_e'(funct3);
        end
        else
        begin
          dec.illegal = 1'b1;
        end
      end
      rv_pkg::OP_STORE:
      begin
        if (funct3 == rv_pkg::FUNCT3_SW)
        begin
          dec.imm = imm_s;
          dec.use_imm = 1'b1;
          dec.is_store = 1'b1;
        end
        else
        begin
          dec.illegal = 1'b1;
        end
      end
      rv_pkg::OP_REG_IMM:
      begin
        if (imm_f7_ok)
        begin
          // insn[30] selects SRAI but is immediate data elsewhere
          dec.alu_op = rv_pkg::alu_op_e'({(funct3 == rv_pkg::FUNCT3_SRX) && insn[30], funct3});
          dec.use_imm = 1'b1;
          dec.rf_we = 1'b1;
        end
        else
        begin
          dec.illegal = 1'b1;
        end
      end
      rv_pkg::OP_REG_REG:
      begin
        if (reg_f7_ok)
        begin
          dec.alu_op = rv_pkg::alu_op_e'({insn[30], funct3});
          dec.rf_we = 1'b1;
        end
        else
        begin
          dec.illegal = 1'b1;
        end
      end
      rv_pkg::OP_SYSTEM:
      begin
        // only ECALL is accepted
        dec.is_halt = (insn[31:7] == '0);
        dec.illegal = (insn[31:7] != '0);
      end
      default:
      begin
        dec.illegal = 1'b1;
      end
    endcase
  end

endmodule

//--- rv_pc_unit.sv
`timescale 1ns/10ps

module rv_pc_unit (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::dec_t  dec,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t alu_result,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4
);

  rv_pkg::word_t pc_next;
  rv_pkg::word_t pc_rel;
  logic taken;

  assign pc_plus4 = pc + rv_pkg::INSN_BYTES;
  // shared target for branches and JAL
  assign pc_rel = pc + dec.imm;

  // branch condition, signed cases in two's complement
  always_comb
  begin
    case (dec.br_op)
      rv_pkg::BR_EQ:
        taken = (rs1_data == rs2_data);
      rv_pkg::BR_NE:
        taken = (rs1_data != rs2_data);
      rv_pkg::BR_LT:
        taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::BR_GE:
        taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::BR_LTU:
        taken = (rs1_data < rs2_data);
      rv_pkg::BR_GEU:
        taken = (rs1_data >= rs2_data);
      default:
        taken = 1'b0;
    endcase
  end

  always_comb
  begin
    if ((dec.is_branch && taken) || dec.is_jal)
      pc_next = pc_rel;
    else if (dec.is_jalr)
      pc_next = {alu_result[rv_pkg::XLEN-1:1], 1'b0};
    else if (dec.is_halt || dec.illegal)
      // stay on the current instruction
      pc_next = pc;
    else
      pc_next = pc_plus4;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc <= rv_pkg::RESET_PC;
    end
    else
    begin
      pc <= pc_next;
    end
  end

endmodule

//--- rv_pkg.sv
package rv_pkg;

  // machine widths
  localparam int unsigned XLEN = 32;
  localparam int unsigned NUM_REGS = 32;
  localparam int unsigned SHAMT_W = $clog2(XLEN);
  localparam int unsigned BYTES_PER_WORD = XLEN / 8;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  // fetch address out of reset and the sequential step
  localparam word_t RESET_PC = '0;
  localparam word_t INSN_BYTES = 4;

  // byte enables for a full word store
  localparam logic [BYTES_PER_WORD-1:0] STORE_WE_WORD = '1;

  // funct7 and funct3 patterns checked by the decoder
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;
  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_SLL = 3'b001;
  localparam logic [2:0] FUNCT3_SRX = 3'b101;
  localparam logic [2:0] FUNCT3_SW = 3'b010;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LUI     = 7'b0110111,
    OP_AUIPC   = 7'b0010111,
    OP_JAL     = 7'b1101111,
    OP_JALR    = 7'b1100111,
    OP_BRANCH  = 7'b1100011,
    OP_STORE   = 7'b0100011,
    OP_REG_IMM = 7'b0010011,
    OP_REG_REG = 7'b0110011,
    OP_SYSTEM  = 7'b1110011
  } opcode_e;

  // encoded as {insn[30], funct3} so the decoder can map it directly
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  // branch conditions use their funct3 values
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_op_e;

  // decoded instruction as seen by the datapath
  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    alu_op_e  alu_op;
    logic     use_imm;
    logic     use_pc;
    logic     rf_we;
    logic     wb_link;
    logic     is_branch;
    br_op_e   br_op;
    logic     is_jal;
    logic     is_jalr;
    logic     is_store;
    logic     is_halt;
    logic     illegal;
  } dec_t;

  // store port towards data memory
  typedef struct packed {
    word_t                     addr;
    word_t                     data;
    logic [BYTES_PER_WORD-1:0] we;
  } store_t;

endpackage

//--- rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data
);

  rv_pkg::word_t regs [rv_pkg::NUM_REGS];

  // asynchronous read ports
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 is cleared by reset and never written afterwards
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we && (rd != '0))
    begin
      regs[rd] <= rd_data;
    end
  end

endmodule
